/* logic/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // Cache geometry
    localparam int ICACHE_SETS    = 16;
    localparam int ICACHE_WAYS    = 4;
    localparam int LINE_BYTES     = 32;
    localparam int BEATS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 5;
    localparam int SET_BITS       = 4;
    localparam int TAG_BITS       = 23;
    localparam int WAY_BITS       = 2;

    // Refill beat geometry, derived
    localparam int BEAT_BITS  = $clog2(BEATS_PER_LINE);
    localparam int BEAT_BYTES = LINE_BYTES / BEATS_PER_LINE;
    localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(BEATS_PER_LINE - 1);

    // Register map, word offsets
    localparam logic [3:0] CSR_CTRL   = 4'd0;
    localparam logic [3:0] CSR_HITS   = 4'd1;
    localparam logic [3:0] CSR_MISSES = 4'd2;
    localparam logic [3:0] CSR_STATUS = 4'd3;

    // Cache view of a fetch address
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [SET_BITS-1:0]    set_idx;
        logic [OFFSET_BITS-1:0] offset;
    } fetch_fields_t;

    // Same word, raw for the bus or split for lookup
    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_t f;
    } fetch_addr_u;

    typedef struct packed {
        logic        valid;
        logic        kill;
        fetch_addr_u pc;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] instr;
        logic        miss;
    } fetch_rsp_t;

    // Memory bus, 64-bit classic
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
        logic [7:0]  sel;
    } wb_mem_req_t;

    typedef struct packed {
        logic        ack;
        logic [63:0] dat;
    } wb_mem_rsp_t;

    // Register bus, 32-bit classic
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_csr_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_csr_rsp_t;

    // One refill beat toward the sets
    typedef struct packed {
        logic                 valid;
        logic [BEAT_BITS-1:0] beat;
        logic [63:0]          word;
    } refill_beat_t;

endpackage

`default_nettype wire

/* logic/icache_set.sv */
`default_nettype none

module icache_set
    import icache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    // Control from the controller
    input  logic         active_i,
    input  logic         inval_i,
    input  logic         rep_active_i,

    // Lookup address and refill data
    input  fetch_addr_u  addr_i,
    input  refill_beat_t beat_i,

    output logic [31:0]  instr_o,
    output logic         hit_o
);

    // Per-way state
    logic [TAG_BITS-1:0]    tag_q  [ICACHE_WAYS];
    logic [ICACHE_WAYS-1:0] valid_q;
    logic [WAY_BITS-1:0]    age_q  [ICACHE_WAYS];
    logic [63:0]            line_q [ICACHE_WAYS][BEATS_PER_LINE];

    // Lookup
    logic [ICACHE_WAYS-1:0] way_hit;
    logic [WAY_BITS-1:0]    hit_way;
    logic [63:0]            hit_word;

    // Replacement and LRU
    logic [WAY_BITS-1:0]    victim;
    logic [WAY_BITS-1:0]    touch_way;
    logic [WAY_BITS-1:0]    touch_age;
    logic                   fill_en;
    logic                   fill_last;
    logic                   hit_touch;
    logic                   touch_en;

    // Tag compare on every way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ICACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w] && (tag_q[w] == addr_i.f.tag);
            if (way_hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit_o = |way_hit;

    // Beat by offset, then 32-bit half
    assign hit_word = line_q[hit_way][addr_i.f.offset[OFFSET_BITS-1 -: BEAT_BITS]];
    assign instr_o  = addr_i.f.offset[2] ? hit_word[63:32] : hit_word[31:0];

    // Oldest way, overridden by lowest invalid way
    always_comb begin
        victim = '0;
        for (int w = 0; w < ICACHE_WAYS; w++) begin
            if (age_q[w] == WAY_BITS'(ICACHE_WAYS - 1)) begin
                victim = WAY_BITS'(w);
            end
        end
        for (int w = ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w]) begin
                victim = WAY_BITS'(w);
            end
        end
    end

    assign fill_en   = active_i && rep_active_i && beat_i.valid;
    assign fill_last = fill_en && (beat_i.beat == LAST_BEAT);
    assign hit_touch = active_i && hit_o && !rep_active_i;
    assign touch_en  = hit_touch || fill_last;
    assign touch_way = fill_last ? victim : hit_way;
    // New line counts as oldest, so every other way ages
    assign touch_age = fill_last ? WAY_BITS'(ICACHE_WAYS - 1) : age_q[hit_way];

    // Valid bits and LRU ages
    always_ff @(posedge clk_i) begin
        if (rst_i || inval_i) begin
            valid_q <= '0;
            for (int w = 0; w < ICACHE_WAYS; w++) begin
                age_q[w] <= '0;
            end
        end else begin
            // Old line stops hitting once its tag is replaced
            if (fill_en && (beat_i.beat == '0)) begin
                valid_q[victim] <= 1'b0;
            end
            if (fill_last) begin
                valid_q[victim] <= 1'b1;
            end
            if (touch_en) begin
                for (int w = 0; w < ICACHE_WAYS; w++) begin
                    if (WAY_BITS'(w) == touch_way) begin
                        age_q[w] <= '0;
                    end else if (age_q[w] < touch_age) begin
                        age_q[w] <= age_q[w] + 1'b1;
                    end
                end
            end
        end
    end

    // Line data, tag goes in with the first beat
    always_ff @(posedge clk_i) begin
        if (fill_en) begin
            line_q[victim][beat_i.beat] <= beat_i.word;
            if (beat_i.beat == '0) begin
                tag_q[victim] <= addr_i.f.tag;
            end
        end
    end

    // Tags stay unique within the set
    a_one_hit: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(way_hit));

    // Fill target holds for the whole line
    a_victim_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        active_i && rep_active_i && $past(active_i && rep_active_i) |-> $stable(victim));

endmodule

`default_nettype wire

/* logic/icache_ctrl.sv */
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  fetch_req_t             req_i,
    input  logic [ICACHE_SETS-1:0] hit_array_i,
    input  logic                   rep_done_i,
    input  logic                   inval_req_i,

    output logic [ICACHE_SETS-1:0] active_array_o,
    output logic                   miss_o,
    output logic                   rep_en_o,
    output logic                   inval_o,
    output logic                   refill_start_o,
    output logic                   inval_busy_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_INVAL
    } state_e;

    state_e              state_q;
    state_e              state_nxt;
    logic                inval_pend_q;
    logic [SET_BITS-1:0] set_idx;

    assign set_idx = req_i.pc.f.set_idx;

    // Addressed set stays selected through its refill
    assign active_array_o = (req_i.valid || state_q == ST_REFILL) ?
                            (ICACHE_SETS'(1) << set_idx) : '0;
    assign miss_o         = req_i.valid && !hit_array_i[set_idx];

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE: begin
                // Invalidate wins over a new miss
                if (inval_req_i || inval_pend_q) begin
                    state_nxt = ST_INVAL;
                end else if (miss_o && !req_i.kill) begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (rep_done_i) begin
                    state_nxt = (inval_req_i || inval_pend_q) ? ST_INVAL : ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= ST_IDLE;
            inval_pend_q <= 1'b0;
        end else begin
            state_q <= state_nxt;
            // Park requests that arrive mid-refill
            if (state_nxt == ST_INVAL) begin
                inval_pend_q <= 1'b0;
            end else if (inval_req_i) begin
                inval_pend_q <= 1'b1;
            end
        end
    end

    assign rep_en_o       = (state_q == ST_REFILL);
    assign inval_o        = (state_q == ST_INVAL);
    assign refill_start_o = (state_q == ST_IDLE) && (state_nxt == ST_REFILL);
    assign inval_busy_o   = inval_req_i || inval_pend_q || (state_q == ST_INVAL);

    a_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(rep_en_o && inval_o));

    a_active_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        req_i.valid |-> $onehot(active_array_o));

endmodule

`default_nettype wire

/* logic/icache_l1.sv */
`default_nettype none

module icache_l1
    import icache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    // Fetch request and refill data
    input  fetch_req_t   req_i,
    input  refill_beat_t beat_i,

    // Refill and invalidate handshake
    input  logic         rep_ready_i,
    input  logic         rep_done_i,
    input  logic         inval_req_i,

    output fetch_rsp_t   rsp_o,
    output logic         rep_en_o,
    output logic         refill_start_o,
    output logic         inval_busy_o
);

    logic [SET_BITS-1:0]    set_idx;
    logic [ICACHE_SETS-1:0] active_array;
    logic [ICACHE_SETS-1:0] hit_array;
    logic [31:0]            instr_array [ICACHE_SETS];
    logic                   rep_active;
    logic                   inval;

    // Set index straight from the split view
    assign set_idx = req_i.pc.f.set_idx;

    // Fill only once the engine holds the line base
    assign rep_active = rep_en_o & rep_ready_i;

    for (genvar i = 0; i < ICACHE_SETS; i++) begin : g_set
        icache_set u_set (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .active_i     (active_array[i]),
            .inval_i      (inval),
            .rep_active_i (rep_active),
            .addr_i       (req_i.pc),
            .beat_i       (beat_i),
            .instr_o      (instr_array[i]),
            .hit_o        (hit_array[i])
        );
    end

    icache_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .hit_array_i    (hit_array),
        .rep_done_i     (rep_done_i),
        .inval_req_i    (inval_req_i),
        .active_array_o (active_array),
        .miss_o         (rsp_o.miss),
        .rep_en_o       (rep_en_o),
        .inval_o        (inval),
        .refill_start_o (refill_start_o),
        .inval_busy_o   (inval_busy_o)
    );

    // Word from the addressed set
    assign rsp_o.instr = instr_array[set_idx];

endmodule

`default_nettype wire

/* logic/icache_refill.sv */
`default_nettype none

module icache_refill
    import icache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    // Request from the cache
    input  logic         rep_en_i,
    input  fetch_addr_u  line_addr_i,

    // Memory bus master side
    input  wb_mem_rsp_t  wb_rsp_i,
    output wb_mem_req_t  wb_req_o,

    // Beats and status toward the cache
    output refill_beat_t beat_o,
    output logic         rep_ready_o,
    output logic         rep_done_o,
    output logic         busy_o
);

    logic                 rep_en_q;
    logic                 busy_q;
    logic                 start;
    logic                 beat_ack;
    logic [31:0]          base_q;
    logic [BEAT_BITS-1:0] beat_cnt_q;

    // New line on a rising rep_en
    assign start    = rep_en_i && !rep_en_q && !busy_q;
    assign beat_ack = busy_q && wb_rsp_i.ack;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rep_en_q   <= 1'b0;
            busy_q     <= 1'b0;
            beat_cnt_q <= '0;
        end else begin
            rep_en_q <= rep_en_i;
            if (start) begin
                busy_q     <= 1'b1;
                beat_cnt_q <= '0;
            end else if (beat_ack) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                // Drop the cycle after the last ack
                if (beat_cnt_q == LAST_BEAT) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Line base with offset cleared
    always_ff @(posedge clk_i) begin
        if (start) begin
            base_q <= {line_addr_i.raw[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        end
    end

    // Classic single reads, one per beat
    assign wb_req_o.cyc = busy_q;
    assign wb_req_o.stb = busy_q;
    assign wb_req_o.adr = base_q + 32'(beat_cnt_q) * BEAT_BYTES;
    assign wb_req_o.sel = '1;

    // Acked data goes straight to the sets
    assign beat_o.valid = beat_ack;
    assign beat_o.beat  = beat_cnt_q;
    assign beat_o.word  = wb_rsp_i.dat;

    assign rep_ready_o = busy_q;
    assign rep_done_o  = beat_ack && (beat_cnt_q == LAST_BEAT);
    // Requested or on the bus
    assign busy_o      = rep_en_i || busy_q;

    // Strobe held with cycle and address until ack
    a_wb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_req_o.stb && !wb_rsp_i.ack |=>
            wb_req_o.cyc && wb_req_o.stb && $stable(wb_req_o.adr));

endmodule

`default_nettype wire

/* logic/icache_csr.sv */
`default_nettype none

module icache_csr
    import icache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    // Register bus slave side
    input  wb_csr_req_t wb_req_i,
    output wb_csr_rsp_t wb_rsp_o,

    // Events and status from the cache
    input  logic        hit_i,
    input  logic        refill_start_i,
    input  logic        refill_busy_i,
    input  logic        inval_busy_i,

    output logic        inval_req_o
);

    logic        req_fire;
    logic        ack_q;
    logic        done_q;
    logic        inval_req_q;
    logic [31:0] hits_q;
    logic [31:0] misses_q;
    logic [31:0] rdata;

    // One transfer per strobe
    assign req_fire = wb_req_i.cyc && wb_req_i.stb && !done_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q       <= 1'b0;
            done_q      <= 1'b0;
            inval_req_q <= 1'b0;
        end else begin
            ack_q  <= req_fire;
            // Rearm once stb drops
            done_q <= (wb_req_i.cyc && wb_req_i.stb) ? (done_q || req_fire) : 1'b0;
            inval_req_q <= req_fire && wb_req_i.we && (wb_req_i.adr == CSR_CTRL) &&
                           wb_req_i.dat[0];
        end
    end

    // Event counters
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hits_q   <= '0;
            misses_q <= '0;
        end else begin
            if (hit_i) begin
                hits_q <= hits_q + 1'b1;
            end
            if (refill_start_i) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    // Read mux, live values
    always_comb begin
        case (wb_req_i.adr)
            CSR_HITS:   rdata = hits_q;
            CSR_MISSES: rdata = misses_q;
            CSR_STATUS: rdata = {30'd0, inval_busy_i, refill_busy_i};
            default:    rdata = '0;
        endcase
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata;
    assign inval_req_o  = inval_req_q;

endmodule

`default_nettype wire

/* logic/icache_top.sv */
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    // Core fetch port
    input  fetch_req_t  fetch_req_i,
    output fetch_rsp_t  fetch_rsp_o,

    // Memory bus, master
    output wb_mem_req_t mem_req_o,
    input  wb_mem_rsp_t mem_rsp_i,

    // Register bus, slave
    input  wb_csr_req_t csr_req_i,
    output wb_csr_rsp_t csr_rsp_o
);

    refill_beat_t beat;
    logic         rep_en;
    logic         rep_ready;
    logic         rep_done;
    logic         refill_busy;
    logic         refill_start;
    logic         inval_req;
    logic         inval_busy;
    logic         fetch_hit;

    // Hit event for the counter
    assign fetch_hit = fetch_req_i.valid && !fetch_rsp_o.miss;

    icache_l1 u_l1 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          (fetch_req_i),
        .beat_i         (beat),
        .rep_ready_i    (rep_ready),
        .rep_done_i     (rep_done),
        .inval_req_i    (inval_req),
        .rsp_o          (fetch_rsp_o),
        .rep_en_o       (rep_en),
        .refill_start_o (refill_start),
        .inval_busy_o   (inval_busy)
    );

    // Line base comes from the held pc
    icache_refill u_refill (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .rep_en_i    (rep_en),
        .line_addr_i (fetch_req_i.pc),
        .wb_rsp_i    (mem_rsp_i),
        .wb_req_o    (mem_req_o),
        .beat_o      (beat),
        .rep_ready_o (rep_ready),
        .rep_done_o  (rep_done),
        .busy_o      (refill_busy)
    );

    icache_csr u_csr (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wb_req_i       (csr_req_i),
        .wb_rsp_o       (csr_rsp_o),
        .hit_i          (fetch_hit),
        .refill_start_i (refill_start),
        .refill_busy_i  (refill_busy),
        .inval_busy_i   (inval_busy),
        .inval_req_o    (inval_req)
    );

endmodule

`default_nettype wire

/* verif/icache_tb_mem.sv */
`default_nettype none

module icache_tb_mem
    import icache_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    // Memory bus slave side
    input  wb_mem_req_t req_i,
    output wb_mem_rsp_t rsp_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int         seed;
    logic [1:0] wait_q;

    // Word at a byte address, derived from the address alone
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5EED0000;
    endfunction

    initial begin
        seed  = 32'h2342;
        rsp_o = '0;
    end

    // Ack after 0 to 3 idle cycles, one beat per ack
    always @(posedge clk_i) begin
        if (rst_i) begin
            rsp_o  <= '0;
            wait_q <= 2'($random(seed));
        end else if (rsp_o.ack) begin
            // Single cycle ack, then a fresh delay for the next beat
            rsp_o.ack <= 1'b0;
            wait_q    <= 2'($random(seed));
        end else if (req_i.cyc && req_i.stb) begin
            if (wait_q == 2'd0) begin
                rsp_o.ack <= 1'b1;
                // Lower half is the lower address
                rsp_o.dat <= {word_at(req_i.adr + 32'd4), word_at(req_i.adr)};
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/icache_tb.sv */
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_FETCH    = 60;
    localparam int MISS_LIMIT = 64;
    // Worst case per fetch plus room for CSR traffic
    localparam int TIMEOUT_NS = N_FETCH * (BEATS_PER_LINE * 4 + 4) * 40 + 20000;

    logic        clk;
    logic        rst;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    wb_mem_req_t mem_req;
    wb_mem_rsp_t mem_rsp;
    wb_csr_req_t csr_req;
    wb_csr_rsp_t csr_rsp;

    int   errors;
    int   seed;
    int   exp_hits;
    int   exp_misses;
    int   ack_count;
    logic exp_miss;
    logic check_en;
    logic no_mem_en;
    logic [31:0] rdat;

    // Scoreboard, per set the resident tags with the most recent first
    logic [TAG_BITS-1:0] lru_q [ICACHE_SETS][$];

    icache_top dut_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp),
        .csr_req_i   (csr_req),
        .csr_rsp_o   (csr_rsp)
    );

    icache_tb_mem u_mem (
        .clk_i (clk),
        .rst_i (rst),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] expected_instr(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5EED0000;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        fetch_addr_u a;
        a.f.tag     = TAG_BITS'(tag);
        a.f.set_idx = SET_BITS'(set);
        a.f.offset  = OFFSET_BITS'(word * 4);
        return a.raw;
    endfunction

    function automatic logic resident(input fetch_addr_u a);
        for (int i = 0; i < lru_q[a.f.set_idx].size(); i++) begin
            if (lru_q[a.f.set_idx][i] == a.f.tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Move to the front, drop the oldest beyond the way count
    task automatic touch_line(input fetch_addr_u a);
        int idx;
        idx = -1;
        for (int i = 0; i < lru_q[a.f.set_idx].size(); i++) begin
            if (lru_q[a.f.set_idx][i] == a.f.tag) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            lru_q[a.f.set_idx].delete(idx);
        end
        lru_q[a.f.set_idx].push_front(a.f.tag);
        if (lru_q[a.f.set_idx].size() > ICACHE_WAYS) begin
            void'(lru_q[a.f.set_idx].pop_back());
        end
    endtask

    // Beat counter for the refill length check
    always @(posedge clk) begin
        if (mem_rsp.ack) begin
            ack_count++;
        end
    end

    a_miss: assert property (@(posedge clk) disable iff (rst)
        fetch_req.valid && check_en |-> fetch_rsp.miss == exp_miss)
        else begin
            errors++;
            $display("ERROR t=%0t fetch_rsp.miss: expected %b, got %b",
                     $time, $sampled(exp_miss), $sampled(fetch_rsp.miss));
        end

    a_instr: assert property (@(posedge clk) disable iff (rst)
        fetch_req.valid && !fetch_rsp.miss |->
            fetch_rsp.instr == expected_instr(fetch_req.pc.raw))
        else begin
            errors++;
            $display("ERROR t=%0t fetch_rsp.instr: expected %h, got %h", $time,
                     expected_instr($sampled(fetch_req.pc.raw)), $sampled(fetch_rsp.instr));
        end

    // Hits and killed misses stay off the memory bus
    a_no_mem: assert property (@(posedge clk) disable iff (rst)
        no_mem_en |-> !mem_req.cyc)
        else begin
            errors++;
            $display("ERROR t=%0t mem_req.cyc: expected 0, got 1", $time);
        end

    // All byte lanes on every refill beat
    a_mem_sel: assert property (@(posedge clk) disable iff (rst)
        mem_req.cyc |-> mem_req.sel == 8'hFF)
        else begin
            errors++;
            $display("ERROR t=%0t mem_req.sel: expected ff, got %h",
                     $time, $sampled(mem_req.sel));
        end

    task automatic fetch(input logic [31:0] a, input logic kill);
        fetch_addr_u pc;
        logic        hit;
        int          cycles;
        pc.raw = a;
        hit    = resident(pc);
        @(negedge clk);
        fetch_req.valid = 1'b1;
        fetch_req.kill  = kill;
        fetch_req.pc    = pc;
        exp_miss        = !hit;
        check_en        = 1'b1;
        @(negedge clk);
        if (hit) begin
            exp_hits++;
            touch_line(pc);
        end else if (!kill) begin
            // Refill in flight, miss falls on the held pc
            exp_misses++;
            check_en = 1'b0;
            cycles   = 0;
            while (fetch_rsp.miss && cycles < MISS_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            assert (!fetch_rsp.miss) else begin
                errors++;
                $display("Refill of address %h never completed", a);
            end
            touch_line(pc);
            // One cycle on the filled line checks its word
            exp_miss = 1'b0;
            check_en = 1'b1;
            @(negedge clk);
            exp_hits++;
        end
        fetch_req.valid = 1'b0;
        fetch_req.kill  = 1'b0;
        check_en        = 1'b0;
    endtask

    task automatic csr_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                              output logic [31:0] data);
        int cycles;
        @(negedge clk);
        csr_req.cyc = 1'b1;
        csr_req.stb = 1'b1;
        csr_req.we  = we;
        csr_req.adr = adr;
        csr_req.dat = wdat;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!csr_rsp.ack && cycles < 16);
        assert (csr_rsp.ack) else begin
            errors++;
            $display("Register access at offset %0d got no ack", adr);
        end
        data        = csr_rsp.dat;
        csr_req.cyc = 1'b0;
        csr_req.stb = 1'b0;
        csr_req.we  = 1'b0;
    endtask

    task automatic check_csr(input logic [3:0] adr, input int expected, input string name);
        logic [31:0] data;
        csr_access(1'b0, adr, 32'd0, data);
        assert (data == 32'(expected)) else begin
            errors++;
            $display("ERROR t=%0t %s: expected %0d, got %0d", $time, name, expected, data);
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int cycles;
        seed       = 32'h2342;
        errors     = 0;
        exp_hits   = 0;
        exp_misses = 0;
        ack_count  = 0;
        exp_miss   = 1'b0;
        check_en   = 1'b0;
        no_mem_en  = 1'b0;
        fetch_req  = '0;
        csr_req    = '0;
        rst        = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Cold miss on a random line, then a full line refill
        ack_count = 0;
        fetch(make_addr($random(seed), 3, 2), 1'b0);
        assert (ack_count == BEATS_PER_LINE) else begin
            errors++;
            $display("ERROR t=%0t ack_count: expected %0d, got %0d",
                     $time, BEATS_PER_LINE, ack_count);
        end

        // Every word of that line hits
        no_mem_en = 1'b1;
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            fetch({fetch_req.pc.raw[31:OFFSET_BITS], OFFSET_BITS'(w * 4)}, 1'b0);
        end
        no_mem_en = 1'b0;

        // Five lines into set 5, the first touched before the fifth
        for (int t = 0; t < 4; t++) begin
            fetch(make_addr(100 + t, 5, t), 1'b0);
        end
        fetch(make_addr(100, 5, 7), 1'b0);
        fetch(make_addr(104, 5, 0), 1'b0);
        fetch(make_addr(101, 5, 1), 1'b0);
        fetch(make_addr(100, 5, 3), 1'b0);

        // Wrong-path miss starts nothing
        no_mem_en = 1'b1;
        fetch(make_addr(777, 9, 4), 1'b1);
        repeat (4) @(negedge clk);
        no_mem_en = 1'b0;
        check_csr(CSR_MISSES, exp_misses, "misses");

        // Whole cache invalidate, then wait for STATUS to settle
        csr_access(1'b1, CSR_CTRL, 32'd1, rdat);
        foreach (lru_q[s]) begin
            lru_q[s].delete();
        end
        cycles = 0;
        do begin
            csr_access(1'b0, CSR_STATUS, 32'd0, rdat);
            cycles++;
        end while (rdat[1] && cycles < 8);
        check_csr(CSR_STATUS, 0, "status");
        fetch(make_addr(100, 5, 0), 1'b0);
        fetch(make_addr(104, 5, 0), 1'b0);

        // Random mix over two sets, more tags than ways
        for (int i = 0; i < 40; i++) begin
            fetch(make_addr(200 + ($random(seed) & 7), 6 + ($random(seed) & 1),
                            $random(seed) & 7), 1'b0);
        end
        check_csr(CSR_HITS, exp_hits, "hits");
        check_csr(CSR_MISSES, exp_misses, "misses");

        $display("Errors: %0d, expected hits: %0d, expected misses: %0d",
                 errors, exp_hits, exp_misses);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/icache_pkg.sv
logic/icache_set.sv
logic/icache_ctrl.sv
logic/icache_l1.sv
logic/icache_refill.sv
logic/icache_csr.sv
logic/icache_top.sv
verif/icache_tb_mem.sv
verif/icache_tb.sv
